//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_ooo_backend \
  --Mdir obj_dir -o tb_ooo_backend

./obj_dir/tb_ooo_backend

//--- src.f
+incdir+include
src/ooo_isa_pkg.sv
src/ooo_core_pkg.sv
src/fu_req_if.sv
src/scoreboard.sv
src/operand_read.sv
src/arch_regfile.sv
src/alu_unit.sv
src/mul_unit.sv
src/ooo_backend.sv
tests/tb_ooo_backend.sv

//--- src/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
  input  logic                     clock,
  input  logic                     reset,
  fu_req_if.receiver               req,
  output ooo_core_pkg::writeback_t wb
);
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  logic [xlen-1:0] result;
  logic            valid_q;
  sb_idx_t         idx_q;
  logic [xlen-1:0] data_q;

  assign req.ready = 1'b1;

  always_comb begin
    case (req.op)
      op_add:  result = req.operand_a + req.operand_b;
      op_sub:  result = req.operand_a - req.operand_b;
      op_and:  result = req.operand_a & req.operand_b;
      op_or:   result = req.operand_a | req.operand_b;
      op_xor:  result = req.operand_a ^ req.operand_b;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid & req.ready;
    end
    if (req.valid && req.ready) begin
      idx_q  <= req.idx;
      data_q <= result;
    end
  end

  assign wb = '{valid: valid_q, idx: idx_q, data: data_q};

endmodule

//--- src/arch_regfile.sv
`timescale 1ns/10ps

module arch_regfile (
  input  logic                         clock,
  input  logic                         reset,
  input  ooo_isa_pkg::reg_idx_t        rs1_addr,
  input  ooo_isa_pkg::reg_idx_t        rs2_addr,
  output logic [ooo_isa_pkg::xlen-1:0] rs1_data,
  output logic [ooo_isa_pkg::xlen-1:0] rs2_data,
  input  ooo_core_pkg::decoder_t       commit_instr,
  output logic                         commit_valid,
  output logic                         retire_valid,
  output ooo_isa_pkg::reg_idx_t        retire_rd,
  output logic [ooo_isa_pkg::xlen-1:0] retire_data
);
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  logic [xlen-1:0] regs_q [num_regs];

  assign rs1_data = regs_q[rs1_addr];
  assign rs2_data = regs_q[rs2_addr];

  // Oldest slot retires as soon as its result is in.
  assign commit_valid = commit_instr.valid;

  assign retire_valid = commit_instr.valid;
  assign retire_rd    = commit_instr.rd;
  assign retire_data  = commit_instr.result;

  // Register 0 is cleared by reset and never written.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (commit_valid && commit_instr.rd != '0) begin
      regs_q[commit_instr.rd] <= commit_instr.result;
    end
  end

endmodule

//--- src/fu_req_if.sv
`timescale 1ns/10ps

interface fu_req_if;
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  logic            valid;
  logic            ready;
  op_e             op;
  sb_idx_t         idx;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;

  modport sender (output valid, output op, output idx, output operand_a,
                  output operand_b, input ready);

  modport receiver (input valid, input op, input idx, input operand_a,
                    input operand_b, output ready);

endinterface

//--- src/mul_unit.sv
`timescale 1ns/10ps

module mul_unit #(
  parameter int mul_stages = 3
) (
  input  logic                     clock,
  input  logic                     reset,
  fu_req_if.receiver               req,
  output ooo_core_pkg::writeback_t wb
);
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  logic [mul_stages-1:0] valid_q;
  sb_idx_t               idx_q  [mul_stages];
  logic [xlen-1:0]       prod_q [mul_stages];

  assign req.ready = 1'b1;

  // Low half of the product enters stage 0.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req.valid & req.ready;
      for (int s = 1; s < mul_stages; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
    idx_q[0]  <= req.idx;
    prod_q[0] <= req.operand_a * req.operand_b;
    for (int s = 1; s < mul_stages; s++) begin
      idx_q[s]  <= idx_q[s-1];
      prod_q[s] <= prod_q[s-1];
    end
  end

  assign wb = '{valid: valid_q[mul_stages-1], idx: idx_q[mul_stages-1],
                data: prod_q[mul_stages-1]};

  // Steering in the operand stage sends only multiplies here.
  only_mul_ops: assert property (@(posedge clock) disable iff (reset)
    req.valid |-> req.op == op_mul);

endmodule

//--- src/ooo_backend.sv
`timescale 1ns/10ps

module ooo_backend #(
  parameter int mul_stages = 3
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         instr_valid,
  output logic                         instr_ready,
  input  ooo_isa_pkg::op_e             instr_op,
  input  ooo_isa_pkg::reg_idx_t        instr_rd,
  input  ooo_isa_pkg::reg_idx_t        instr_rs1,
  input  ooo_isa_pkg::reg_idx_t        instr_rs2,
  input  logic                         instr_use_imm,
  input  logic [ooo_isa_pkg::xlen-1:0] instr_imm,
  output logic                         retire_valid,
  output ooo_isa_pkg::reg_idx_t        retire_rd,
  output logic [ooo_isa_pkg::xlen-1:0] retire_data
);
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  decoder_t                          idu_instr;
  decoder_t                          issue_instr;
  decoder_t                          commit_instr;
  logic                              issue_valid;
  logic                              issue_ready;
  logic                              commit_valid;
  forwarding_t                       fwd;
  writeback_t [write_back_ports-1:0] wb;
  reg_idx_t                          rs1_addr;
  reg_idx_t                          rs2_addr;
  logic [xlen-1:0]                   rs1_data;
  logic [xlen-1:0]                   rs2_data;

  fu_req_if alu_req ();
  fu_req_if mul_req ();

  // Slot index and result are filled in later.
  assign idu_instr = '{op: instr_op, rd: instr_rd, rs1: instr_rs1, rs2: instr_rs2,
                       use_imm: instr_use_imm, imm: instr_imm, idx: '0,
                       valid: 1'b0, result: '0};

  scoreboard u_scoreboard (
    .clock, .reset, .idu2isu_instr(idu_instr), .idu_valid(instr_valid),
    .isu2idu_ready(instr_ready), .issue_instr, .issue_valid, .issue_ready,
    .commit_instr, .commit_valid, .fwd, .wb
  );

  operand_read u_operand_read (
    .clock, .reset, .issue_instr, .issue_valid, .issue_ready, .fwd,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .alu_req, .mul_req
  );

  arch_regfile u_arch_regfile (
    .clock, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .commit_instr, .commit_valid, .retire_valid, .retire_rd, .retire_data
  );

  alu_unit u_alu_unit (.clock, .reset, .req(alu_req), .wb(wb[0]));

  mul_unit #(.mul_stages(mul_stages)) u_mul_unit (
    .clock, .reset, .req(mul_req), .wb(wb[1])
  );

endmodule

//--- src/ooo_core_pkg.sv
package ooo_core_pkg;

  // Scoreboard geometry.
  localparam int scoreboard_depth = 4;
  localparam int scoreboard_index = 2;

  // ALU on port 0, multiplier on port 1.
  localparam int write_back_ports = 2;

  typedef logic [scoreboard_index-1:0] sb_idx_t;

  // One decoded operation, plus its slot and result once known.
  typedef struct packed {
    ooo_isa_pkg::op_e                 op;
    ooo_isa_pkg::reg_idx_t            rd;
    ooo_isa_pkg::reg_idx_t            rs1;
    ooo_isa_pkg::reg_idx_t            rs2;
    logic                             use_imm;
    logic [ooo_isa_pkg::xlen-1:0]     imm;
    sb_idx_t                          idx;
    logic                             valid;
    logic [ooo_isa_pkg::xlen-1:0]     result;
  } decoder_t;

  typedef struct packed {
    logic     issued;
    decoder_t instr;
  } scoreboard_t;

  typedef struct packed {
    logic                         valid;
    sb_idx_t                      idx;
    logic [ooo_isa_pkg::xlen-1:0] data;
  } writeback_t;

  // Snapshot of the slots and this cycle's results.
  typedef struct packed {
    logic [scoreboard_depth-1:0]       issued;
    decoder_t [scoreboard_depth-1:0]   instr;
    writeback_t [write_back_ports-1:0] wb;
  } forwarding_t;

endpackage

//--- src/ooo_isa_pkg.sv
package ooo_isa_pkg;

  // Data path width.
  localparam int xlen = 32;

  // Architectural register count, register 0 reads as zero.
  localparam int num_regs = 16;

  typedef logic [3:0] reg_idx_t;

  // Register-to-register operations.
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_mul = 3'd5
  } op_e;

endpackage

//--- src/operand_read.sv
`timescale 1ns/10ps

module operand_read (
  input  logic                         clock,
  input  logic                         reset,
  input  ooo_core_pkg::decoder_t       issue_instr,
  input  logic                         issue_valid,
  output logic                         issue_ready,
  input  ooo_core_pkg::forwarding_t    fwd,
  output ooo_isa_pkg::reg_idx_t        rs1_addr,
  output ooo_isa_pkg::reg_idx_t        rs2_addr,
  input  logic [ooo_isa_pkg::xlen-1:0] rs1_data,
  input  logic [ooo_isa_pkg::xlen-1:0] rs2_data,
  fu_req_if.sender                     alu_req,
  fu_req_if.sender                     mul_req
);
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  typedef struct packed {
    logic            pending;
    logic [xlen-1:0] value;
  } src_t;

  src_t            src_a;
  src_t            src_b;
  logic            is_mul;
  logic            unit_ready;
  logic            stall;
  logic            dispatch;
  logic [xlen-1:0] operand_b;

  // Walks back from the issue slot; the first free slot ends the live window.
  function automatic src_t resolve(input reg_idx_t rs, input logic needed,
                                   input logic [xlen-1:0] rf_value,
                                   input sb_idx_t issue_idx, input forwarding_t view);
    src_t    res;
    logic    in_window;
    logic    found;
    sb_idx_t slot;
    sb_idx_t hit;
    res       = '{pending: 1'b0, value: rf_value};
    in_window = 1'b1;
    found     = 1'b0;
    hit       = '0;
    for (int d = 1; d < scoreboard_depth; d++) begin
      slot = issue_idx - sb_idx_t'(d);
      if (!view.issued[slot]) begin
        in_window = 1'b0;
      end
      if (in_window && !found && view.instr[slot].rd == rs) begin
        found = 1'b1;
        hit   = slot;
      end
    end
    if (needed && rs != '0 && found) begin
      if (view.instr[hit].valid) begin
        res.value = view.instr[hit].result;
      end else begin
        res.pending = 1'b1;
        for (int p = 0; p < write_back_ports; p++) begin
          if (view.wb[p].valid && view.wb[p].idx == hit) begin
            res.pending = 1'b0;
            res.value   = view.wb[p].data;
          end
        end
      end
    end
    return res;
  endfunction

  assign rs1_addr = issue_instr.rs1;
  assign rs2_addr = issue_instr.rs2;

  assign src_a = resolve(issue_instr.rs1, 1'b1, rs1_data, issue_instr.idx, fwd);
  assign src_b = resolve(issue_instr.rs2, ~issue_instr.use_imm, rs2_data,
                         issue_instr.idx, fwd);

  assign operand_b = issue_instr.use_imm ? issue_instr.imm : src_b.value;

  assign is_mul      = issue_instr.op == op_mul;
  assign unit_ready  = is_mul ? mul_req.ready : alu_req.ready;
  assign stall       = src_a.pending | src_b.pending;
  assign issue_ready = ~stall & unit_ready;
  assign dispatch    = issue_valid & ~stall;

  assign alu_req.valid     = dispatch & ~is_mul;
  assign alu_req.op        = issue_instr.op;
  assign alu_req.idx       = issue_instr.idx;
  assign alu_req.operand_a = src_a.value;
  assign alu_req.operand_b = operand_b;

  assign mul_req.valid     = dispatch & is_mul;
  assign mul_req.op        = issue_instr.op;
  assign mul_req.idx       = issue_instr.idx;
  assign mul_req.operand_a = src_a.value;
  assign mul_req.operand_b = operand_b;

  // No result is in flight for the slot being filled.
  no_wb_to_issue_slot: assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> !(fwd.wb[0].valid && fwd.wb[0].idx == issue_instr.idx) &&
                    !(fwd.wb[1].valid && fwd.wb[1].idx == issue_instr.idx));

endmodule

//--- src/scoreboard.sv
`timescale 1ns/10ps

module scoreboard (
  input  logic                      clock,
  input  logic                      reset,
  input  ooo_core_pkg::decoder_t    idu2isu_instr,
  input  logic                      idu_valid,
  output logic                      isu2idu_ready,
  output ooo_core_pkg::decoder_t    issue_instr,
  output logic                      issue_valid,
  input  logic                      issue_ready,
  output ooo_core_pkg::decoder_t    commit_instr,
  input  logic                      commit_valid,
  output ooo_core_pkg::forwarding_t fwd,
  input  ooo_core_pkg::writeback_t [ooo_core_pkg::write_back_ports-1:0] wb
);
  import ooo_core_pkg::*;

  scoreboard_t [scoreboard_depth-1:0] mem_q;
  scoreboard_t [scoreboard_depth-1:0] mem_n;
  sb_idx_t                            issue_ptr_q;
  sb_idx_t                            commit_ptr_q;
  logic [scoreboard_index:0]          sb_cnt;
  logic                               issue_full;
  logic                               accept;

  // Occupied slots.
  always_comb begin
    sb_cnt = '0;
    for (int i = 0; i < scoreboard_depth; i++) begin
      sb_cnt = sb_cnt + {{scoreboard_index{1'b0}}, mem_q[i].issued};
    end
  end

  assign issue_full = sb_cnt == (scoreboard_index + 1)'(scoreboard_depth);

  always_comb begin
    issue_instr     = idu2isu_instr;
    issue_instr.idx = issue_ptr_q;
  end

  assign issue_valid   = idu_valid & ~issue_full;
  assign isu2idu_ready = issue_ready & ~issue_full;
  assign accept        = idu_valid & isu2idu_ready;

  assign commit_instr = mem_q[commit_ptr_q].instr;

  always_comb begin
    mem_n = mem_q;

    if (accept) begin
      mem_n[issue_ptr_q].issued = 1'b1;
      mem_n[issue_ptr_q].instr  = issue_instr;
    end

    // Results land only in live slots.
    for (int p = 0; p < write_back_ports; p++) begin
      if (wb[p].valid && mem_q[wb[p].idx].issued) begin
        mem_n[wb[p].idx].instr.valid  = 1'b1;
        mem_n[wb[p].idx].instr.result = wb[p].data;
      end
    end

    if (commit_valid) begin
      mem_n[commit_ptr_q].issued      = 1'b0;
      mem_n[commit_ptr_q].instr.valid = 1'b0;
    end
  end

  always_comb begin
    for (int i = 0; i < scoreboard_depth; i++) begin
      fwd.issued[i] = mem_q[i].issued;
      fwd.instr[i]  = mem_q[i].instr;
    end
    fwd.wb = wb;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < scoreboard_depth; i++) begin
        mem_q[i].issued      <= 1'b0;
        mem_q[i].instr.valid <= 1'b0;
      end
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
    end else begin
      mem_q <= mem_n;
      if (accept) begin
        issue_ptr_q <= issue_ptr_q + sb_idx_t'(1);
      end
      if (commit_valid) begin
        commit_ptr_q <= commit_ptr_q + sb_idx_t'(1);
      end
    end
  end

  // The register file only commits a live slot.
  commit_needs_issued: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> mem_q[commit_ptr_q].issued);

  // A new operation never lands on an occupied slot.
  accept_into_free_slot: assert property (@(posedge clock) disable iff (reset)
    accept |-> !mem_q[issue_ptr_q].issued);

endmodule

//--- include/tb_program.svh
`ifndef tb_program_svh
`define tb_program_svh

typedef ooo_isa_pkg::op_e tb_op_e;

// One directed operation.
typedef struct packed {
  tb_op_e                       op;
  ooo_isa_pkg::reg_idx_t        rd;
  ooo_isa_pkg::reg_idx_t        rs1;
  ooo_isa_pkg::reg_idx_t        rs2;
  logic                         use_imm;
  logic [ooo_isa_pkg::xlen-1:0] imm;
} tb_row_t;

localparam int tb_num_rows = 23;

// Immediates, dependent chain, mul then ALU, mul burst, register 0.
localparam tb_row_t tb_program [tb_num_rows] = '{
  '{ooo_isa_pkg::op_add, 4'd1,  4'd0, 4'd0, 1'b1, 32'h0000_0005},
  '{ooo_isa_pkg::op_add, 4'd2,  4'd0, 4'd0, 1'b1, 32'h0000_0007},
  '{ooo_isa_pkg::op_xor, 4'd3,  4'd0, 4'd0, 1'b1, 32'h0000_00ff},
  '{ooo_isa_pkg::op_or,  4'd4,  4'd0, 4'd0, 1'b1, 32'h0000_0030},
  '{ooo_isa_pkg::op_add, 4'd5,  4'd1, 4'd2, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_sub, 4'd6,  4'd5, 4'd1, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_and, 4'd7,  4'd6, 4'd3, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd8,  4'd7, 4'd2, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_add, 4'd9,  4'd8, 4'd0, 1'b1, 32'h0000_0001},
  '{ooo_isa_pkg::op_xor, 4'd10, 4'd9, 4'd5, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd11, 4'd2, 4'd3, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_add, 4'd12, 4'd1, 4'd0, 1'b1, 32'h0000_0003},
  '{ooo_isa_pkg::op_or,  4'd13, 4'd4, 4'd2, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd14, 4'd1, 4'd2, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd15, 4'd2, 4'd3, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd11, 4'd4, 4'd1, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd12, 4'd5, 4'd6, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_mul, 4'd13, 4'd7, 4'd0, 1'b1, 32'h0000_0003},
  '{ooo_isa_pkg::op_mul, 4'd14, 4'd3, 4'd3, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_add, 4'd0,  4'd1, 4'd0, 1'b1, 32'h0000_0009},
  '{ooo_isa_pkg::op_add, 4'd1,  4'd0, 4'd0, 1'b1, 32'h0000_0000},
  '{ooo_isa_pkg::op_or,  4'd2,  4'd0, 4'd3, 1'b0, 32'h0000_0000},
  '{ooo_isa_pkg::op_sub, 4'd5,  4'd0, 4'd0, 1'b1, 32'h0000_0001}
};

`endif

//--- tests/tb_ooo_backend.sv
`timescale 1ns/10ps

module tb_ooo_backend;
  import ooo_isa_pkg::*;

  `include "tb_program.svh"

  localparam int mul_stages  = 3;
  localparam int num_random  = 40;
  localparam int num_rows    = tb_num_rows + num_random;
  localparam int period_ns   = 40;
  localparam int reset_ns    = 3 * period_ns;
  localparam int watchdog_ns = num_rows * (mul_stages + 8) * period_ns + reset_ns;

  // Table rows of the independent multiply burst.
  // A stall while driving them can only come from a full scoreboard.
  localparam int burst_first = 13;
  localparam int burst_last  = 18;

  typedef struct packed {
    reg_idx_t        rd;
    logic [xlen-1:0] data;
  } expect_t;

  logic            clock;
  logic            reset;
  logic            instr_valid;
  logic            instr_ready;
  op_e             instr_op;
  reg_idx_t        instr_rd;
  reg_idx_t        instr_rs1;
  reg_idx_t        instr_rs2;
  logic            instr_use_imm;
  logic [xlen-1:0] instr_imm;
  logic            retire_valid;
  reg_idx_t        retire_rd;
  logic [xlen-1:0] retire_data;

  logic [31:0]     lfsr_state;
  logic [xlen-1:0] ref_regs [num_regs];
  tb_row_t         rows [$];
  expect_t         expected_q [$];
  int              row_stalls;
  int              burst_stalls;

  ooo_backend #(.mul_stages(mul_stages)) u_ooo_backend (
    .clock, .reset, .instr_valid, .instr_ready, .instr_op, .instr_rd, .instr_rs1,
    .instr_rs2, .instr_use_imm, .instr_imm, .retire_valid, .retire_rd, .retire_data
  );

  always #(period_ns / 2) clock = ~clock;

  task automatic stop_with_failure(input string reason);
    $display("Failure: %s", reason);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [xlen-1:0] got,
                       input logic [xlen-1:0] expected);
    if (got !== expected) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
      $display("Something failed");
      $fatal(1, "simulation stopped at the first mismatch");
    end
  endtask

  // Galois LFSR stepped once per bit.
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic tb_row_t random_row();
    tb_row_t    r;
    logic [2:0] op_bits;
    op_bits   = 3'(lfsr_bits(3) % 32'd6);
    r.op      = tb_op_e'(op_bits);
    r.rd      = 4'(lfsr_bits(4));
    r.rs1     = 4'(lfsr_bits(4));
    r.rs2     = 4'(lfsr_bits(4));
    r.use_imm = lfsr_bit();
    r.imm     = lfsr_bits(32);
    return r;
  endfunction

  // Reference semantics. Register 0 always reads zero.
  function automatic logic [xlen-1:0] model_result(input tb_row_t r);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] res;
    a = (r.rs1 == '0) ? '0 : ref_regs[r.rs1];
    b = r.use_imm ? r.imm : ((r.rs2 == '0) ? '0 : ref_regs[r.rs2]);
    case (r.op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_mul:  res = a * b;
      default: res = '0;
    endcase
    return res;
  endfunction

  // Holds the row until an edge sees instr_ready high.
  task automatic drive_row(input tb_row_t r, output int stalls);
    expect_t e;
    logic    accepted;
    stalls        = 0;
    instr_valid   = 1'b1;
    instr_op      = r.op;
    instr_rd      = r.rd;
    instr_rs1     = r.rs1;
    instr_rs2     = r.rs2;
    instr_use_imm = r.use_imm;
    instr_imm     = r.imm;
    e.rd   = r.rd;
    e.data = model_result(r);
    expected_q.push_back(e);
    if (r.rd != '0) begin
      ref_regs[r.rd] = e.data;
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      if (instr_ready) begin
        accepted = 1'b1;
      end else begin
        stalls++;
      end
      @(posedge clock);
      #1;
    end
  endtask

  always @(negedge clock) begin
    expect_t e;
    if (!reset && retire_valid) begin
      if (expected_q.size() == 0) begin
        stop_with_failure("retire_valid rose with no operation left to retire");
      end else begin
        e = expected_q.pop_front();
        check("retire_rd", 32'(retire_rd), 32'(e.rd));
        check("retire_data", retire_data, e.data);
      end
    end
  end

  initial begin
    #(watchdog_ns);
    stop_with_failure("watchdog expired before every operation retired");
  end

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    instr_valid   = 1'b0;
    instr_op      = op_add;
    instr_rd      = '0;
    instr_rs1     = '0;
    instr_rs2     = '0;
    instr_use_imm = 1'b0;
    instr_imm     = '0;
    lfsr_state    = 32'hb3b7772a;
    row_stalls    = 0;
    burst_stalls  = 0;
    for (int i = 0; i < num_regs; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < tb_num_rows; i++) begin
      rows.push_back(tb_program[i]);
    end
    for (int i = 0; i < num_random; i++) begin
      rows.push_back(random_row());
    end

    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i], row_stalls);
      if (i >= burst_first && i <= burst_last) begin
        burst_stalls += row_stalls;
      end
    end
    instr_valid = 1'b0;

    // Drain and leave time for a late duplicate retire.
    while (expected_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (mul_stages + 4) @(posedge clock);

    if (burst_stalls > 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_failure("instr_ready stayed high through the multiply burst");
    end
  end

endmodule
